// ==== design/log_series_pkg.sv ====
package log_series_pkg;

	// ==================================================
	// Word and operand types
	// ==================================================

	// IEEE single precision, raw bits
	typedef logic [31:0] fp_word_t;

	// One item: series argument and the value it is added to
	typedef struct packed
	{
		fp_word_t y;
		fp_word_t offset;
	} series_in_t;

	// Operands of one multiply or add request
	typedef struct packed
	{
		fp_word_t a;
		fp_word_t b;
	} op_pair_t;

	// ==================================================
	// Series coefficients
	// ==================================================

	localparam int MAX_TERMS = 8;

	// c_n = -2/(2n+1) for n = 0..7
	localparam fp_word_t COEF_TABLE [MAX_TERMS] = '{
		32'hC000_0000,
		32'hBF2A_AAAB,
		32'hBECC_CCCD,
		32'hBE92_4925,
		32'hBE63_8E39,
		32'hBE3A_2E8C,
		32'hBE1D_89D9,
		32'hBE08_8889
	};

	typedef logic [$clog2(MAX_TERMS)-1:0] term_idx_t;

endpackage

// ==== design/operand_capture.sv ====
`timescale 1ns/1ps

module operand_capture
	import log_series_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       in_strobe,
	input  series_in_t in_data,
	input  logic       finish,
	output logic       start,
	output series_in_t operands,
	output logic       busy
);

	logic accept;

	// Strobes that arrive during an item are dropped
	assign accept = in_strobe && !busy;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			start <= 1'b0;
			busy  <= 1'b0;
		end
		else
		begin
			start <= accept;
			if (accept)
				busy <= 1'b1;
			else if (finish)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			operands <= in_data;
	end

	// Sequencer only finishes an item that was accepted
	a_finish_when_busy: assert property (@(posedge clk) disable iff (reset)
		finish |-> busy);

endmodule

// ==== design/series_sequencer.sv ====
`timescale 1ns/1ps

module series_sequencer
	import log_series_pkg::*;
#(
	parameter int N_TERMS = 8
)
(
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  series_in_t operands,
	output logic       mult_issue,
	output op_pair_t   mult_pair,
	input  logic       mult_ready,
	input  fp_word_t   mult_value,
	output logic       add_issue,
	output op_pair_t   add_pair,
	input  logic       add_ready,
	input  fp_word_t   add_value,
	output logic       out_strobe,
	output fp_word_t   out_result,
	output logic       finish
);

	typedef enum logic [2:0]
	{
		st_idle,
		st_square,
		st_coef_mul,
		st_accumulate,
		st_power_mul
	} state_t;

	state_t    state;
	term_idx_t idx;
	fp_word_t  y_square;
	fp_word_t  power;
	fp_word_t  accumulator;
	logic      last_term;

	if (N_TERMS < 1 || N_TERMS > MAX_TERMS)
	begin : g_bad_terms
		$error("N_TERMS must lie in 1..MAX_TERMS");
	end

	assign last_term = (idx == term_idx_t'(N_TERMS - 1));
	assign finish    = (state == st_accumulate) && add_ready && last_term;

	// ==================================================
	// Step ordering
	// ==================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state      <= st_idle;
			idx        <= '0;
			mult_issue <= 1'b0;
			add_issue  <= 1'b0;
			out_strobe <= 1'b0;
			out_result <= '0;
		end
		else
		begin
			mult_issue <= 1'b0;
			add_issue  <= 1'b0;
			out_strobe <= 1'b0;
			case (state)
				st_idle:
					if (start)
					begin
						state      <= st_square;
						idx        <= '0;
						mult_issue <= 1'b1;
					end
				st_square:
					if (mult_ready)
					begin
						state      <= st_coef_mul;
						mult_issue <= 1'b1;
					end
				st_coef_mul:
					if (mult_ready)
					begin
						state     <= st_accumulate;
						add_issue <= 1'b1;
					end
				st_accumulate:
					if (add_ready)
					begin
						if (last_term)
						begin
							state      <= st_idle;
							out_strobe <= 1'b1;
							out_result <= add_value;
						end
						else
						begin
							state      <= st_power_mul;
							mult_issue <= 1'b1;
						end
					end
				st_power_mul:
					if (mult_ready)
					begin
						state      <= st_coef_mul;
						idx        <= idx + term_idx_t'(1);
						mult_issue <= 1'b1;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Working values, loaded from the returned results
	always_ff @(posedge clk)
	begin
		if (state == st_idle && start)
		begin
			power       <= operands.y;
			accumulator <= operands.offset;
		end
		if (state == st_square && mult_ready)
			y_square <= mult_value;
		if (state == st_power_mul && mult_ready)
			power <= mult_value;
		if (state == st_accumulate && add_ready)
			accumulator <= add_value;
	end

	// ==================================================
	// Operand selection
	// ==================================================

	always_comb
	begin
		case (state)
			st_coef_mul:  mult_pair = '{a: COEF_TABLE[idx], b: power};
			st_power_mul: mult_pair = '{a: power, b: y_square};
			default:      mult_pair = '{a: power, b: power};
		endcase
	end

	// Multiplier port still holds the term while the adder works
	assign add_pair = '{a: accumulator, b: mult_value};

	a_mult_ready_state: assert property (@(posedge clk) disable iff (reset)
		mult_ready |-> state inside {st_square, st_coef_mul, st_power_mul});

	a_add_ready_state: assert property (@(posedge clk) disable iff (reset)
		add_ready |-> state == st_accumulate);

	a_idx_range: assert property (@(posedge clk) disable iff (reset)
		idx < N_TERMS);

endmodule

// ==== design/operator_port.sv ====
`timescale 1ns/1ps

module operator_port
	import log_series_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     issue,
	input  op_pair_t pair,
	output logic     ready,
	output fp_word_t value,
	output logic     req,
	output op_pair_t operands,
	input  logic     done,
	input  fp_word_t result
);

	// Set from issue until the unit answers
	logic pending;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			req     <= 1'b0;
			ready   <= 1'b0;
			pending <= 1'b0;
		end
		else
		begin
			req   <= issue;
			ready <= done && pending;
			if (issue)
				pending <= 1'b1;
			else if (done)
				pending <= 1'b0;
		end
	end

	// Request operands and returned value
	always_ff @(posedge clk)
	begin
		if (issue)
			operands <= pair;
		if (done)
			value <= result;
	end

	// External unit handles one request at a time
	a_no_issue_pending: assert property (@(posedge clk) disable iff (reset)
		issue |-> !pending);

	a_done_expected: assert property (@(posedge clk) disable iff (reset)
		done |-> pending);

endmodule

// ==== design/log_series_top.sv ====
`timescale 1ns/1ps

module log_series_top
	import log_series_pkg::*;
#(
	parameter int N_TERMS = 8
)
(
	input  logic       clk,
	input  logic       reset,
	input  logic       in_strobe,
	input  series_in_t in_data,
	output logic       busy,
	output logic       out_strobe,
	output fp_word_t   out_result,
	output logic       mult_req,
	output op_pair_t   mult_operands,
	input  logic       mult_done,
	input  fp_word_t   mult_result,
	output logic       add_req,
	output op_pair_t   add_operands,
	input  logic       add_done,
	input  fp_word_t   add_result
);

	logic       start;
	logic       finish;
	series_in_t operands;
	logic       mult_issue;
	op_pair_t   mult_pair;
	logic       mult_ready;
	fp_word_t   mult_value;
	logic       add_issue;
	op_pair_t   add_pair;
	logic       add_ready;
	fp_word_t   add_value;

	// ==================================================
	// Input side
	// ==================================================

	operand_capture i_operand_capture (
		.clk      (clk),
		.reset    (reset),
		.in_strobe(in_strobe),
		.in_data  (in_data),
		.finish   (finish),
		.start    (start),
		.operands (operands),
		.busy     (busy)
	);

	series_sequencer #(
		.N_TERMS(N_TERMS)
	) i_series_sequencer (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.operands  (operands),
		.mult_issue(mult_issue),
		.mult_pair (mult_pair),
		.mult_ready(mult_ready),
		.mult_value(mult_value),
		.add_issue (add_issue),
		.add_pair  (add_pair),
		.add_ready (add_ready),
		.add_value (add_value),
		.out_strobe(out_strobe),
		.out_result(out_result),
		.finish    (finish)
	);

	// ==================================================
	// External arithmetic units
	// ==================================================

	operator_port i_mult_port (
		.clk     (clk),
		.reset   (reset),
		.issue   (mult_issue),
		.pair    (mult_pair),
		.ready   (mult_ready),
		.value   (mult_value),
		.req     (mult_req),
		.operands(mult_operands),
		.done    (mult_done),
		.result  (mult_result)
	);

	operator_port i_add_port (
		.clk     (clk),
		.reset   (reset),
		.issue   (add_issue),
		.pair    (add_pair),
		.ready   (add_ready),
		.value   (add_value),
		.req     (add_req),
		.operands(add_operands),
		.done    (add_done),
		.result  (add_result)
	);

endmodule

// ==== test/fp_unit_model.sv ====
`timescale 1ns/1ps

module fp_unit_model
	import log_series_pkg::*;
#(
	parameter bit IS_ADD      = 1'b0,
	parameter int MAX_LATENCY = 4,
	parameter int SEED        = 67694
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     req,
	input  op_pair_t operands,
	output logic     done,
	output fp_word_t result
);

	integer   seed;
	int       latency;
	fp_word_t answer;

	// Single precision product or sum of one operand pair
	function automatic fp_word_t compute(op_pair_t pair);
		shortreal a;
		shortreal b;
		shortreal r;
		a = $bitstoshortreal(pair.a);
		b = $bitstoshortreal(pair.b);
		if (IS_ADD)
			r = a + b;
		else
			r = a * b;
		return $shortrealtobits(r);
	endfunction

	// One request at a time, answered after 1 to MAX_LATENCY cycles
	initial
	begin
		seed   = SEED;
		done   = 1'b0;
		result = '0;
		forever
		begin
			@(negedge clk);
			if (!reset && req)
			begin
				answer  = compute(operands);
				latency = 1 + ($unsigned($random(seed)) % MAX_LATENCY);
				repeat (latency) @(posedge clk);
				#1;
				done   = 1'b1;
				result = answer;
				@(posedge clk);
				#1;
				done = 1'b0;
			end
		end
	end

endmodule

// ==== test/log_series_tb.sv ====
`timescale 1ns/1ps

module log_series_tb
	import log_series_pkg::*;
();

	localparam int N_TERMS     = 8;
	localparam int NUM_Y       = 9;
	localparam int NUM_ENTRIES = NUM_Y * 3;
	localparam int MAX_LATENCY = 4;
	localparam int RAND_SEED   = 67694;
	// Every operation costs its latency plus three register stages
	localparam int ITEM_CYCLES    = 3 * N_TERMS * (MAX_LATENCY + 3) + 20;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * ITEM_CYCLES + 100;

	logic       clk;
	logic       reset;
	logic       in_strobe;
	series_in_t in_data;
	logic       busy;
	logic       out_strobe;
	fp_word_t   out_result;
	logic       mult_req;
	op_pair_t   mult_operands;
	logic       mult_done;
	fp_word_t   mult_result;
	logic       add_req;
	op_pair_t   add_operands;
	logic       add_done;
	fp_word_t   add_result;

	integer seed;
	int     cycles       = 0;
	int     out_count    = 0;
	int     mult_count   = 0;
	int     add_count    = 0;
	logic   mult_pending = 1'b0;
	logic   add_pending  = 1'b0;

	// Stimulus table with expected results
	string    entry_name   [NUM_ENTRIES];
	fp_word_t entry_y      [NUM_ENTRIES];
	fp_word_t entry_offset [NUM_ENTRIES];
	fp_word_t entry_expect [NUM_ENTRIES];

	log_series_top #(
		.N_TERMS(N_TERMS)
	) i_log_series_top (
		.clk          (clk),
		.reset        (reset),
		.in_strobe    (in_strobe),
		.in_data      (in_data),
		.busy         (busy),
		.out_strobe   (out_strobe),
		.out_result   (out_result),
		.mult_req     (mult_req),
		.mult_operands(mult_operands),
		.mult_done    (mult_done),
		.mult_result  (mult_result),
		.add_req      (add_req),
		.add_operands (add_operands),
		.add_done     (add_done),
		.add_result   (add_result)
	);

	fp_unit_model #(.IS_ADD(1'b0), .MAX_LATENCY(MAX_LATENCY), .SEED(RAND_SEED)) i_mult_model (
		.clk(clk), .reset(reset), .req(mult_req), .operands(mult_operands),
		.done(mult_done), .result(mult_result)
	);

	fp_unit_model #(.IS_ADD(1'b1), .MAX_LATENCY(MAX_LATENCY), .SEED(RAND_SEED)) i_add_model (
		.clk(clk), .reset(reset), .req(add_req), .operands(add_operands),
		.done(add_done), .result(add_result)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==================================================
	// Error reporting
	// ==================================================

	task automatic fail_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("MISMATCH test=%s expected=0x%h actual=0x%h", name, expected, actual);
		$display("TEST FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic fail_note(string what);
		$display("ERROR: %s", what);
		$display("TEST FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected)
		else
			fail_mismatch(name, expected, actual);
	endtask

	task automatic check_true(logic cond, string what);
		assert (cond === 1'b1)
		else
			fail_note(what);
	endtask

	// ==================================================
	// Reference model
	// ==================================================

	function automatic fp_word_t sp_mul(fp_word_t a, fp_word_t b);
		shortreal product;
		product = $bitstoshortreal(a) * $bitstoshortreal(b);
		return $shortrealtobits(product);
	endfunction

	function automatic fp_word_t sp_add(fp_word_t a, fp_word_t b);
		shortreal sum;
		sum = $bitstoshortreal(a) + $bitstoshortreal(b);
		return $shortrealtobits(sum);
	endfunction

	// offset + sum of c_n * y^(2n+1), rounded after every operation
	function automatic fp_word_t ref_series(fp_word_t y, fp_word_t offset);
		fp_word_t square;
		fp_word_t power;
		fp_word_t acc;
		int       n;
		square = sp_mul(y, y);
		power  = y;
		acc    = offset;
		for (n = 0; n < N_TERMS; n++)
		begin
			acc = sp_add(acc, sp_mul(COEF_TABLE[n], power));
			if (n < N_TERMS - 1)
				power = sp_mul(power, square);
		end
		return acc;
	endfunction

	task automatic build_table();
		fp_word_t y_list   [NUM_Y];
		string    y_label  [NUM_Y];
		fp_word_t off_list [3];
		shortreal y_rand;
		int       r;
		int       k;
		int       j;
		y_list = '{32'h0000_0000, 32'h3F00_0000, 32'hBF00_0000, 32'h3F80_0000,
			32'h3DCC_CCCD, 32'h0, 32'h0, 32'h0, 32'h0};
		y_label = '{"y_zero", "y_half", "y_neg_half", "y_one", "y_tenth", "", "", "", ""};
		// Zero and plus or minus ln 2
		off_list = '{32'h0000_0000, 32'h3F31_7218, 32'hBF31_7218};
		for (k = 5; k < NUM_Y; k++)
		begin
			r          = $random(seed) % 10000;
			y_rand     = r / 10000.0;
			y_list[k]  = $shortrealtobits(y_rand);
			y_label[k] = $sformatf("y_rand%0d", k - 5);
		end
		for (k = 0; k < NUM_Y; k++)
			for (j = 0; j < 3; j++)
			begin
				entry_name[k * 3 + j]   = $sformatf("%s_off%0d", y_label[k], j);
				entry_y[k * 3 + j]      = y_list[k];
				entry_offset[k * 3 + j] = off_list[j];
				entry_expect[k * 3 + j] = ref_series(y_list[k], off_list[j]);
			end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	task automatic apply_entry(int i);
		int mult_base;
		int add_base;
		int strobe_base;
		while (busy)
			@(negedge clk);
		mult_base   = mult_count;
		add_base    = add_count;
		strobe_base = out_count;
		@(posedge clk);
		#1;
		in_strobe = 1'b1;
		in_data   = '{y: entry_y[i], offset: entry_offset[i]};
		@(posedge clk);
		#1;
		in_strobe = 1'b0;
		@(negedge clk);
		check_true(busy, "busy did not rise after an accepted in_strobe");
		// Stray strobe in the middle of odd entries
		if (i % 2 == 1)
		begin
			@(posedge clk);
			#1;
			in_strobe = 1'b1;
			in_data   = '{y: 32'h3F80_0000, offset: 32'h4000_0000};
			@(posedge clk);
			#1;
			in_strobe = 1'b0;
		end
		@(negedge clk);
		while (!out_strobe)
		begin
			check_true(busy, "busy fell before out_strobe");
			@(negedge clk);
		end
		check_true(!busy, "busy still high in the out_strobe cycle");
		check_value(entry_name[i], entry_expect[i], out_result);
		if (entry_y[i] == 32'h0)
			check_value({entry_name[i], "_is_offset"}, entry_offset[i], out_result);
		@(posedge clk);
		check_value({entry_name[i], "_strobes"}, 1, out_count - strobe_base);
		check_value({entry_name[i], "_mult_reqs"}, 2 * N_TERMS, mult_count - mult_base);
		check_value({entry_name[i], "_add_reqs"}, N_TERMS, add_count - add_base);
	endtask

	// Strobe and request counts, one request per unit at a time
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (out_strobe)
				out_count++;
			if (mult_req)
			begin
				check_true(!mult_pending, "multiplier got a request before its previous done");
				mult_count++;
				mult_pending = 1'b1;
			end
			else if (mult_done)
				mult_pending = 1'b0;
			if (add_req)
			begin
				check_true(!add_pending, "adder got a request before its previous done");
				add_count++;
				add_pending = 1'b1;
			end
			else if (add_done)
				add_pending = 1'b0;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			fail_note($sformatf("timed out after %0d cycles waiting on the DUT", cycles));
	end

	initial
	begin
		seed      = RAND_SEED;
		reset     = 1'b1;
		in_strobe = 1'b0;
		in_data   = '0;
		build_table();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		// Idle outputs before the first item
		repeat (5)
		begin
			@(negedge clk);
			check_true(!busy && !out_strobe && !mult_req && !add_req,
				"outputs not idle after reset");
			check_value("reset_result", 32'h0, out_result);
		end
		for (int i = 0; i < NUM_ENTRIES; i++)
			apply_entry(i);
		repeat (20) @(negedge clk);
		check_value("total_strobes", NUM_ENTRIES, out_count);
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== sources.f ====
design/log_series_pkg.sv
design/operand_capture.sv
design/series_sequencer.sv
design/operator_port.sv
design/log_series_top.sv
test/fp_unit_model.sv
test/log_series_tb.sv

// ==== Bender.yml ====
package:
  name: log_series

sources:
  - design/log_series_pkg.sv
  - design/operand_capture.sv
  - design/series_sequencer.sv
  - design/operator_port.sv
  - design/log_series_top.sv
  - target: test
    files:
      - test/fp_unit_model.sv
      - test/log_series_tb.sv
